//--- gpio_pinmap.svh
// console pad numbering.
// included inside a module body, so every includer gets its own copy.

localparam int PIN_LED        = 0;

// d-pad.
localparam int PIN_DPAD_U     = 1;
localparam int PIN_DPAD_D     = 2;
localparam int PIN_DPAD_L     = 3;
localparam int PIN_DPAD_R     = 4;

// face and system buttons.
localparam int PIN_BTN_A      = 5;
localparam int PIN_BTN_B      = 6;
localparam int PIN_BTN_X      = 7;
localparam int PIN_BTN_Y      = 8;
localparam int PIN_BTN_START  = 9;
localparam int PIN_BTN_SELECT = 10; // last mapped pad.

//--- gpio_pkg.sv
package gpio_pkg;

	// apb bus widths.
	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// led, four d-pad directions and six buttons.
	localparam int N_PADS_DEFAULT = 11;

	// register map, one word per register.
	// bit 3 of the offset picks the block and bit 2 picks the register in it.
	localparam apb_addr_t REG_OUT  = 16'h0000; // led output level.
	localparam apb_addr_t REG_DIR  = 16'h0004; // led output enable.
	localparam apb_addr_t REG_IN   = 16'h0008; // synchronized pad levels.
	localparam apb_addr_t REG_EDGE = 16'h000c; // sticky rising edges, write one to clear.

endpackage

//--- gpio_reg_if.sv
`timescale 1ns/1ps

// one register access from the apb slave into a register block.
interface gpio_reg_if;
	import gpio_pkg::*;

	logic      wr_en;   // one cycle strobe.
	logic      reg_sel; // second register of the block.
	apb_data_t wdata;
	apb_data_t rdata;   // combinational from the block.

	modport host (
		output wr_en,
		output reg_sel,
		output wdata,
		input  rdata
	);

	modport dev (
		input  wr_en,
		input  reg_sel,
		input  wdata,
		output rdata
	);

endinterface

//--- reset_sync.sv
`timescale 1ns/1ps

module reset_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic clk,
	input  logic rst_n_i,
	output logic rst_n_sync_o
);

	logic [SYNC_STAGES-1:0] chain_q;

	// assert at once, release after SYNC_STAGES edges.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			chain_q <= '0;
		end else begin
			chain_q <= (chain_q << 1) | 1'b1; // shift ones in.
		end
	end

	assign rst_n_sync_o = chain_q[SYNC_STAGES-1];

endmodule

//--- gpio_apb_slave.sv
`timescale 1ns/1ps

module gpio_apb_slave (
	input  logic                clk,
	input  logic                rst_n_sync,

	input  logic                apbs_psel_i,
	input  logic                apbs_penable_i,
	input  logic                apbs_pwrite_i,
	input  gpio_pkg::apb_addr_t apbs_paddr_i,
	input  gpio_pkg::apb_data_t apbs_pwdata_i,
	output gpio_pkg::apb_data_t apbs_prdata_o,
	output logic                apbs_pready_o,
	output logic                apbs_pslverr_o,

	gpio_reg_if.host            out_if,
	gpio_reg_if.host            in_if
);

	import gpio_pkg::*;

	logic access; // apb access phase.
	logic legal;
	logic sel_in; // input capture block addressed.

	// only the four mapped words are legal.
	always_comb begin
		case (apbs_paddr_i)
			REG_OUT, REG_DIR, REG_IN, REG_EDGE: legal = 1'b1;
			default:                            legal = 1'b0;
		endcase
	end

	assign access = apbs_psel_i && apbs_penable_i;
	assign sel_in = apbs_paddr_i[3];

	assign out_if.wr_en   = access && apbs_pwrite_i && legal && !sel_in;
	assign out_if.reg_sel = apbs_paddr_i[2];
	assign out_if.wdata   = apbs_pwdata_i;

	assign in_if.wr_en    = access && apbs_pwrite_i && legal && sel_in;
	assign in_if.reg_sel  = apbs_paddr_i[2];
	assign in_if.wdata    = apbs_pwdata_i;

	always_comb begin
		apbs_prdata_o = '0;
		if (access && !apbs_pwrite_i && legal) begin
			apbs_prdata_o = sel_in ? in_if.rdata : out_if.rdata;
		end
	end

	assign apbs_pready_o  = 1'b1; // zero wait states.
	assign apbs_pslverr_o = access && !legal;

	a_err_in_access: assert property (@(posedge clk) disable iff (!rst_n_sync)
		$rose(apbs_pslverr_o) |-> apbs_psel_i && apbs_penable_i);

	a_one_block_wr: assert property (@(posedge clk) disable iff (!rst_n_sync)
		$onehot0({out_if.wr_en, in_if.wr_en}));

endmodule

//--- gpio_out_ctrl.sv
`timescale 1ns/1ps

module gpio_out_ctrl #(
	parameter int N_PADS = gpio_pkg::N_PADS_DEFAULT
) (
	input  logic              clk,
	input  logic              rst_n_sync,
	gpio_reg_if.dev           bus,
	output logic [N_PADS-1:0] padout_o,
	output logic [N_PADS-1:0] padoe_o
);

	import gpio_pkg::*;
	`include "gpio_pinmap.svh"

	localparam logic [N_PADS-1:0] LED_BIT = N_PADS'(1) << PIN_LED;

	logic out_q;
	logic dir_q;

	// reg_sel low is REG_OUT, high is REG_DIR.
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			out_q <= 1'b0;
			dir_q <= 1'b0;
		end else if (bus.wr_en) begin
			if (bus.reg_sel) begin
				dir_q <= bus.wdata[0];
			end else begin
				out_q <= bus.wdata[0];
			end
		end
	end

	assign bus.rdata = apb_data_t'(bus.reg_sel ? dir_q : out_q);

	// only the led is an output, the rest stay tied low.
	for (genvar i = 0; i < N_PADS; i++) begin : g_pad
		if (i == PIN_LED) begin : g_led
			assign padout_o[i] = out_q;
			assign padoe_o[i]  = dir_q;
		end else begin : g_unused
			assign padout_o[i] = 1'b0;
			assign padoe_o[i]  = 1'b0;
		end
	end

	a_unused_oe_low: assert property (@(posedge clk)
		(padoe_o & ~LED_BIT) == '0);

endmodule

//--- gpio_in_capture.sv
`timescale 1ns/1ps

module gpio_in_capture #(
	parameter int N_PADS = gpio_pkg::N_PADS_DEFAULT
) (
	input  logic              clk,
	input  logic              rst_n_sync,
	gpio_reg_if.dev           bus,
	input  logic [N_PADS-1:0] padin_i,
	output logic              irq_o
);

	import gpio_pkg::*;
	`include "gpio_pinmap.svh"

	// d-pad and button pads, anything above the map is a plain input.
	function automatic logic [N_PADS-1:0] btn_mask();
		logic [N_PADS-1:0] m;
		m = '0;
		for (int i = PIN_DPAD_U; i <= PIN_BTN_SELECT && i < N_PADS; i++) begin
			m[i] = 1'b1;
		end
		return m;
	endfunction

	localparam logic [N_PADS-1:0] BTN_MASK = btn_mask();

	logic [N_PADS-1:0] sync1_q;
	logic [N_PADS-1:0] sync2_q;
	logic [N_PADS-1:0] prev_q;  // sync2_q one cycle later.
	logic [N_PADS-1:0] edge_q;
	logic [N_PADS-1:0] rise;
	logic [N_PADS-1:0] clr;

	assign rise = sync2_q & ~prev_q & BTN_MASK;
	assign clr  = (bus.wr_en && bus.reg_sel) ? (bus.wdata[N_PADS-1:0] & BTN_MASK) : '0;

	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
			edge_q  <= '0;
		end else begin
			sync1_q <= padin_i;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
			edge_q  <= (edge_q & ~clr) | rise; // set wins over clear.
		end
	end

	// reg_sel low is REG_IN, high is REG_EDGE.
	assign bus.rdata = bus.reg_sel ? apb_data_t'(edge_q) : apb_data_t'(sync2_q);

	assign irq_o = |edge_q;

	// each new flag needs a synchronized low-to-high one cycle before.
	a_edge_has_cause: assert property (@(posedge clk) disable iff (!rst_n_sync)
		(edge_q & ~$past(edge_q) & ~$past(sync2_q & ~prev_q)) == '0);

endmodule

//--- gpio_top.sv
`timescale 1ns/1ps

module gpio_top #(
	parameter int N_PADS = gpio_pkg::N_PADS_DEFAULT
) (
	input  logic                clk,
	input  logic                rst_n,

	input  logic                apbs_psel_i,
	input  logic                apbs_penable_i,
	input  logic                apbs_pwrite_i,
	input  gpio_pkg::apb_addr_t apbs_paddr_i,
	input  gpio_pkg::apb_data_t apbs_pwdata_i,
	output gpio_pkg::apb_data_t apbs_prdata_o,
	output logic                apbs_pready_o,
	output logic                apbs_pslverr_o,

	output logic [N_PADS-1:0]   padout_o,
	output logic [N_PADS-1:0]   padoe_o,
	input  logic [N_PADS-1:0]   padin_i,
	output logic                irq_o
);

	logic rst_n_sync;

	gpio_reg_if out_if ();
	gpio_reg_if in_if ();

	reset_sync #(
		.SYNC_STAGES (2)
	) i_reset_sync (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.rst_n_sync_o (rst_n_sync)
	);

	gpio_apb_slave i_apb_slave (
		.clk            (clk),
		.rst_n_sync     (rst_n_sync),
		.apbs_psel_i    (apbs_psel_i),
		.apbs_penable_i (apbs_penable_i),
		.apbs_pwrite_i  (apbs_pwrite_i),
		.apbs_paddr_i   (apbs_paddr_i),
		.apbs_pwdata_i  (apbs_pwdata_i),
		.apbs_prdata_o  (apbs_prdata_o),
		.apbs_pready_o  (apbs_pready_o),
		.apbs_pslverr_o (apbs_pslverr_o),
		.out_if         (out_if.host),
		.in_if          (in_if.host)
	);

	// led output and direction.
	gpio_out_ctrl #(
		.N_PADS (N_PADS)
	) i_out_ctrl (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.bus        (out_if.dev),
		.padout_o   (padout_o),
		.padoe_o    (padoe_o)
	);

	// pad sampling, edge flags and interrupt.
	gpio_in_capture #(
		.N_PADS (N_PADS)
	) i_in_capture (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.bus        (in_if.dev),
		.padin_i    (padin_i),
		.irq_o      (irq_o)
	);

endmodule

//--- tb_gpio_top.sv
`timescale 1ns/1ps

module tb_gpio_top;

	import gpio_pkg::*;
	`include "gpio_pinmap.svh"

	localparam int N_PADS     = N_PADS_DEFAULT;
	localparam int WAIT_LIMIT = 50;
	localparam int BTN_BITS   = (1 << (PIN_BTN_SELECT + 1)) - (1 << PIN_DPAD_U);

	localparam logic [N_PADS-1:0] BTN_MASK = N_PADS'(BTN_BITS);
	localparam logic [N_PADS-1:0] LED_BIT  = N_PADS'(1) << PIN_LED;

	logic              clk;
	logic              rst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	apb_addr_t         paddr;
	apb_data_t         pwdata;
	apb_data_t         prdata;
	logic              pready;
	logic              pslverr;
	logic [N_PADS-1:0] padout;
	logic [N_PADS-1:0] padoe;
	logic [N_PADS-1:0] padin;
	logic              irq;

	logic [16:0] lfsr_state;

	// reference model state.
	logic [1:0]        model_rst_q;
	logic              model_rst_n;
	logic              exp_out;
	logic              exp_dir;
	logic [N_PADS-1:0] pad_d1;
	logic [N_PADS-1:0] pad_d2; // what REG_IN shows.
	logic [N_PADS-1:0] pad_d3;
	logic [N_PADS-1:0] exp_edge;
	logic [N_PADS-1:0] edge_clr;
	logic [N_PADS-1:0] exp_padout;
	logic [N_PADS-1:0] exp_padoe;
	apb_data_t         exp_rdata;
	apb_data_t         exp_prdata; // zero outside a read access.

	gpio_top #(
		.N_PADS (N_PADS)
	) i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.apbs_psel_i    (psel),
		.apbs_penable_i (penable),
		.apbs_pwrite_i  (pwrite),
		.apbs_paddr_i   (paddr),
		.apbs_pwdata_i  (pwdata),
		.apbs_prdata_o  (prdata),
		.apbs_pready_o  (pready),
		.apbs_pslverr_o (pslverr),
		.padout_o       (padout),
		.padoe_o        (padoe),
		.padin_i        (padin),
		.irq_o          (irq)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		$display("[ERROR] time %0t %s: got 0x%0h, expected 0x%0h",
			$time, name, got, expected);
		stop_with_failure();
	endtask

	task automatic report_timeout(input string what);
		$display("timed out waiting for %s", what);
		stop_with_failure();
	endtask

	// x^17 + x^14 + 1.
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic is_mapped(input apb_addr_t a);
		return (a == REG_OUT) || (a == REG_DIR) || (a == REG_IN) || (a == REG_EDGE);
	endfunction

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic drive_pads(input logic [N_PADS-1:0] v);
		@(posedge clk);
		padin <= v;
	endtask

	// setup phase, then access phase until pready.
	task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t data);
		int cycles;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) report_timeout("apbs_pready_o");
		end while (!pready);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		apb_access(1'b1, addr, data);
	endtask

	task automatic apb_read(input apb_addr_t addr);
		apb_access(1'b0, addr, '0);
	endtask

	task automatic read_all_regs();
		apb_read(REG_OUT);
		apb_read(REG_DIR);
		apb_read(REG_IN);
		apb_read(REG_EDGE);
	endtask

	task automatic wait_irq(input logic level);
		int cycles;
		cycles = 0;
		while (irq !== level) begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) report_timeout("irq_o");
		end
	endtask

	// design reset releases two edges after rst_n.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			model_rst_q <= '0;
		end else begin
			model_rst_q <= {model_rst_q[0], 1'b1};
		end
	end

	assign model_rst_n = model_rst_q[1];

	assign edge_clr = (psel && penable && pwrite && paddr == REG_EDGE) ?
		pwdata[N_PADS-1:0] : '0;

	always_ff @(posedge clk or negedge model_rst_n) begin
		if (!model_rst_n) begin
			exp_out  <= 1'b0;
			exp_dir  <= 1'b0;
			pad_d1   <= '0;
			pad_d2   <= '0;
			pad_d3   <= '0;
			exp_edge <= '0;
		end else begin
			if (psel && penable && pwrite && paddr == REG_OUT) exp_out <= pwdata[0];
			if (psel && penable && pwrite && paddr == REG_DIR) exp_dir <= pwdata[0];
			pad_d1   <= padin;
			pad_d2   <= pad_d1;
			pad_d3   <= pad_d2;
			// set wins.
			exp_edge <= (exp_edge & ~edge_clr) | (pad_d2 & ~pad_d3 & BTN_MASK);
		end
	end

	assign exp_padout = N_PADS'(exp_out) << PIN_LED;
	assign exp_padoe  = N_PADS'(exp_dir) << PIN_LED;

	always_comb begin
		case (paddr)
			REG_OUT:  exp_rdata = 32'(exp_out);
			REG_DIR:  exp_rdata = 32'(exp_dir);
			REG_IN:   exp_rdata = 32'(pad_d2);
			REG_EDGE: exp_rdata = 32'(exp_edge);
			default:  exp_rdata = '0;
		endcase
	end

	assign exp_prdata = (psel && penable && !pwrite) ? exp_rdata : '0;

	a_padout: assert property (@(posedge clk) disable iff (!rst_n) padout == exp_padout)
		else report_mismatch("padout_o", $sampled(padout), $sampled(exp_padout));

	a_padoe: assert property (@(posedge clk) disable iff (!rst_n) padoe == exp_padoe)
		else report_mismatch("padoe_o", $sampled(padoe), $sampled(exp_padoe));

	a_unused_low: assert property (@(posedge clk) ((padout | padoe) & ~LED_BIT) == '0)
		else report_mismatch("padout_o|padoe_o", $sampled(padout | padoe), 32'h0);

	a_irq: assert property (@(posedge clk) disable iff (!rst_n) irq == |exp_edge)
		else report_mismatch("irq_o", $sampled(irq), $sampled(|exp_edge));

	a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready)
		else report_mismatch("apbs_pready_o", $sampled(pready), 32'h1);

	a_prdata: assert property (@(posedge clk) disable iff (!rst_n) prdata == exp_prdata)
		else report_mismatch("apbs_prdata_o", $sampled(prdata), $sampled(exp_prdata));

	a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr == (psel && penable && !is_mapped(paddr)))
		else report_mismatch("apbs_pslverr_o", $sampled(pslverr),
			$sampled(psel && penable && !is_mapped(paddr)));

	// half a cycle after rst_n falls the led pad is already off.
	a_reset_drop: assert property (@(negedge clk) !rst_n |-> (padout | padoe) == '0)
		else report_mismatch("padout_o|padoe_o", $sampled(padout | padoe), 32'h0);

	initial begin
		logic [31:0] r;
		logic [31:0] hold;
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		padin      = '0;
		lfsr_state = 17'd88179;

		idle(10);
		rst_n <= 1'b1;
		idle(3);
		read_all_regs();

		// led output and direction.
		apb_write(REG_OUT, 32'h1);
		apb_write(REG_DIR, 32'h1);
		apb_read(REG_OUT);
		apb_read(REG_DIR);
		apb_write(REG_OUT, 32'hffff_fffe);
		apb_read(REG_OUT);
		apb_write(REG_OUT, 32'h1);

		// led pad rising sets nothing, a button does.
		drive_pads(LED_BIT);
		idle(4);
		apb_read(REG_EDGE);
		drive_pads(LED_BIT | (N_PADS'(1) << PIN_BTN_A));
		wait_irq(1'b1);
		apb_read(REG_EDGE);
		apb_write(REG_EDGE, 32'(1) << PIN_BTN_A);
		wait_irq(1'b0);
		apb_read(REG_EDGE);

		repeat (40) begin
			random_bits(N_PADS, r);
			drive_pads(r[N_PADS-1:0]);
			random_bits(2, hold);
			idle(2 + int'(hold[1:0]));
			apb_read(REG_IN);
			apb_read(REG_EDGE);
			random_bits(N_PADS, r);
			apb_write(REG_EDGE, r);
		end

		drive_pads('0);
		idle(4);
		apb_write(REG_EDGE, '1);
		wait_irq(1'b0);

		// illegal accesses must leave every register alone.
		apb_write(REG_OUT, 32'h0);
		apb_write(REG_DIR, 32'h0);
		drive_pads(N_PADS'(1) << PIN_BTN_B);
		wait_irq(1'b1);
		apb_write(16'h0001, '1);
		apb_write(16'h0010, '1);
		apb_write(16'h1004, '1);
		apb_write(16'h000e, '1);
		apb_read(16'h0002);
		apb_read(16'h0018);
		read_all_regs();

		// reset in the middle of the run.
		apb_write(REG_OUT, 32'h1);
		apb_write(REG_DIR, 32'h1);
		drive_pads('0);
		idle(4);
		@(posedge clk);
		rst_n <= 1'b0;
		idle(3);
		rst_n <= 1'b1;
		idle(3);
		read_all_regs();

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- files.f
+incdir+.
gpio_pkg.sv
gpio_reg_if.sv
reset_sync.sv
gpio_apb_slave.sv
gpio_out_ctrl.sv
gpio_in_capture.sv
gpio_top.sv
tb_gpio_top.sv

//--- Bender.yml
package:
  name: gpio_console

export_include_dirs:
  - .

sources:
  - files:
      - gpio_pkg.sv
      - gpio_reg_if.sv
      - reset_sync.sv
      - gpio_apb_slave.sv
      - gpio_out_ctrl.sv
      - gpio_in_capture.sv
      - gpio_top.sv
  - target: test
    files:
      - tb_gpio_top.sv
